// ==== sources.f ====
src/alut_reg_pkg.sv
src/alut_table_pkg.sv
src/alut_reg_bank.sv
src/alut_timebase.sv
src/alut_addr_check.sv
src/alut_age_check.sv
src/alut_table.sv
src/alut_top.sv
tests/alut_tb.sv

// ==== src/alut_addr_check.sv ====
// address checker, one lookup and one learn per CMD_CHECK
// table read has one cycle of latency, so the scan takes ALUT_DEPTH+2 cycles
// d_addr, s_addr and s_port must hold while the scan runs
// d_port holds its value until the next check ends
`timescale 1ns/1ns

module alut_addr_check
   import alut_reg_pkg::*, alut_table_pkg::*;
(
   input  logic            pclk3,
   input  logic            n_p_reset3,
   input  alut_cmd_t       command,
   input  alut_cfg_t       cfg,
   input  alut_time_t      curr_time,
   input  alut_entry_t     rd_entry,
   output alut_tbl_req_t   tbl_req,
   output logic            add_check_active,
   output alut_port_mask_t d_port,
   output alut_inv_evt_t   evt_nrm
);

   localparam int LAST_CNT = ALUT_DEPTH + 1;   // the write cycle

   logic [$clog2(ALUT_DEPTH+2)-1:0] cnt;
   logic            eval_vld;      // rd_entry belongs to this scan
   alut_idx_t       eval_idx;      // index of rd_entry
   logic            write_cyc;
   logic            evict;
   alut_idx_t       learn_idx;
   logic            dst_hit;
   alut_port_t      dst_port;
   logic            src_hit;
   alut_idx_t       src_idx;
   logic            free_found;
   alut_idx_t       free_idx;
   alut_idx_t       rr_ptr;        // next victim
   mac_addr_t       victim_mac;
   alut_port_t      victim_port;
   alut_port_mask_t next_d_port;

   assign eval_vld  = add_check_active && (cnt != 0) && (cnt != LAST_CNT);
   assign eval_idx  = alut_idx_t'(cnt - 1);
   assign write_cyc = add_check_active && (cnt == LAST_CNT);
   assign evict     = !src_hit && !free_found;
   assign learn_idx = src_hit ? src_idx : (free_found ? free_idx : rr_ptr);

   always_comb
   begin
      tbl_req.rd_idx         = alut_idx_t'(cnt);   // wraps harmlessly at the end
      tbl_req.wr_en          = write_cyc;
      tbl_req.wr_idx         = learn_idx;
      tbl_req.wr_entry.valid = 1'b1;
      tbl_req.wr_entry.mac   = cfg.s_addr;
      tbl_req.wr_entry.port  = cfg.s_port;
      tbl_req.wr_entry.stamp = curr_time;
   end

   // host beats a table hit, a miss floods all but the source port
   always_comb
   begin
      next_d_port = '0;
      if (cfg.d_addr == cfg.mac_addr)
         next_d_port[HOST_BIT] = 1'b1;
      else if (dst_hit)
         next_d_port[dst_port] = 1'b1;
      else
      begin
         next_d_port[3:0]        = 4'hf;
         next_d_port[cfg.s_port] = 1'b0;
      end
   end

   // ------------------------------------------------------------------
   // scan control
   // ------------------------------------------------------------------
   always_ff @(posedge pclk3 or negedge n_p_reset3)
   begin
      if (!n_p_reset3)
      begin
         add_check_active <= 1'b0;
         cnt              <= '0;
         rr_ptr           <= '0;
         d_port           <= '0;
         evt_nrm          <= '0;
      end
      else
      begin
         evt_nrm.strobe <= 1'b0;
         if (!add_check_active)
            add_check_active <= (command == CMD_CHECK);
         else if (write_cyc)
         begin
            add_check_active <= 1'b0;
            cnt              <= '0;
            d_port           <= next_d_port;
            if (evict)                     // table full, overwrite victim
            begin
               rr_ptr         <= rr_ptr + 1'b1;
               evt_nrm.strobe <= 1'b1;
               evt_nrm.addr   <= victim_mac;
               evt_nrm.port   <= victim_port;
            end
         end
         else
            cnt <= cnt + 1'b1;
      end
   end

   // ------------------------------------------------------------------
   // scan results, cleared as a check starts
   // ------------------------------------------------------------------
   always_ff @(posedge pclk3 or negedge n_p_reset3)
   begin
      if (!n_p_reset3)
      begin
         dst_hit     <= 1'b0;
         dst_port    <= '0;
         src_hit     <= 1'b0;
         src_idx     <= '0;
         free_found  <= 1'b0;
         free_idx    <= '0;
         victim_mac  <= '0;
         victim_port <= '0;
      end
      else if (!add_check_active && (command == CMD_CHECK))
      begin
         dst_hit    <= 1'b0;
         src_hit    <= 1'b0;
         free_found <= 1'b0;
      end
      else if (eval_vld)
      begin
         if (rd_entry.valid && (rd_entry.mac == cfg.d_addr))
         begin
            dst_hit  <= 1'b1;
            dst_port <= rd_entry.port;
         end
         if (rd_entry.valid && (rd_entry.mac == cfg.s_addr))
         begin
            src_hit <= 1'b1;      // refresh in place
            src_idx <= eval_idx;
         end
         if (!rd_entry.valid && !free_found)
         begin
            free_found <= 1'b1;   // first free slot only
            free_idx   <= eval_idx;
         end
         if (eval_idx == rr_ptr)
         begin
            victim_mac  <= rd_entry.mac;
            victim_port <= rd_entry.port;
         end
      end
   end

endmodule

// ==== src/alut_age_check.sv ====
// age checker, one pass over the table per CMD_AGE
// entry k is read in scan cycle k and cleared in cycle k+1
// age is computed modulo 2^32, so a wrapped time still ages correctly
`timescale 1ns/1ns

module alut_age_check
   import alut_reg_pkg::*, alut_table_pkg::*;
(
   input  logic          pclk3,
   input  logic          n_p_reset3,
   input  alut_cmd_t     command,
   input  alut_time_t    best_bfr_age,
   input  alut_time_t    curr_time,
   input  alut_entry_t   rd_entry,
   output alut_tbl_req_t tbl_req,
   output logic          age_check_active,
   output alut_inv_evt_t evt_age
);

   localparam int LAST_CNT = ALUT_DEPTH;   // last entry comes back here

   logic [$clog2(ALUT_DEPTH+1)-1:0] cnt;
   alut_time_t age;
   logic       stale;                      // clear rd_entry this cycle

   assign age   = curr_time - rd_entry.stamp;
   assign stale = age_check_active && (cnt != 0) && rd_entry.valid &&
                  (age > best_bfr_age);

   // write back the entry just read, with valid dropped
   always_comb
   begin
      tbl_req.rd_idx         = alut_idx_t'(cnt);
      tbl_req.wr_en          = stale;
      tbl_req.wr_idx         = alut_idx_t'(cnt - 1);
      tbl_req.wr_entry       = rd_entry;
      tbl_req.wr_entry.valid = 1'b0;
   end

   // ------------------------------------------------------------------
   // walk control and event
   // ------------------------------------------------------------------
   always_ff @(posedge pclk3 or negedge n_p_reset3)
   begin
      if (!n_p_reset3)
      begin
         age_check_active <= 1'b0;
         cnt              <= '0;
         evt_age          <= '0;
      end
      else
      begin
         evt_age.strobe <= stale;          // one per cleared entry
         if (stale)
         begin
            evt_age.addr <= rd_entry.mac;
            evt_age.port <= rd_entry.port;
         end
         if (!age_check_active)
            age_check_active <= (command == CMD_AGE);
         else if (cnt == LAST_CNT)
         begin
            age_check_active <= 1'b0;
            cnt              <= '0;
         end
         else
            cnt <= cnt + 1'b1;
      end
   end

endmodule

// ==== src/alut_reg_bank.sv ====
// APB register bank of the ALUT, no wait states and no error response
// prdata is loaded in the setup phase and is zero outside the access phase
// frame registers should not be written while a check is busy
// a command write while busy is dropped, software polls AL_STATUS
`timescale 1ns/1ns

module alut_reg_bank
   import alut_reg_pkg::*, alut_table_pkg::*;
(
   input  logic            pclk3,
   input  logic            n_p_reset3,
   input  logic            psel,
   input  logic            penable,
   input  logic            pwrite,
   input  apb_addr_t       paddr,
   input  apb_data_t       pwdata,
   input  alut_time_t      curr_time,
   input  logic            add_check_active,
   input  logic            age_check_active,
   input  alut_port_mask_t d_port,
   input  alut_inv_evt_t   evt_nrm,
   input  alut_inv_evt_t   evt_age,
   output alut_cfg_t       cfg,
   output alut_cmd_t       command,
   output apb_data_t       prdata
);

   logic        read_en;       // setup phase of a read
   logic        write_en;      // access phase of a write
   logic        busy;
   logic        clear_reused;
   logic        reused;        // sticky, set by eviction
   logic [31:0] d_addr_l;
   logic [15:0] d_addr_u;
   logic [31:0] s_addr_l;
   logic [15:0] s_addr_u;
   logic [1:0]  s_port;
   logic [31:0] mac_addr_l;
   logic [15:0] mac_addr_u;
   logic [31:0] bb_age;
   logic [7:0]  div_clk;
   logic [31:0] lst_inv_addr_l;
   logic [15:0] lst_inv_addr_u;
   logic [1:0]  lst_inv_port;
   apb_data_t   status;

   assign read_en      = psel & ~penable & ~pwrite;
   assign write_en     = psel & penable & pwrite;
   assign busy         = add_check_active | age_check_active;
   assign clear_reused = read_en & (paddr == AL_STATUS) & ~busy;

   always_comb
   begin
      cfg.mac_addr     = {mac_addr_u, mac_addr_l};
      cfg.d_addr       = {d_addr_u, d_addr_l};
      cfg.s_addr       = {s_addr_u, s_addr_l};
      cfg.s_port       = s_port;
      cfg.best_bfr_age = bb_age;
      cfg.div_clk      = div_clk;
   end

   always_comb
   begin
      status                    = '0;
      status[STATUS_BUSY_BIT]   = busy;
      status[STATUS_AGING_BIT]  = age_check_active;
      status[STATUS_REUSED_BIT] = reused;
   end

   // ------------------------------------------------------------------
   // read mux
   // ------------------------------------------------------------------
   always_ff @(posedge pclk3 or negedge n_p_reset3)
   begin
      if (!n_p_reset3)
         prdata <= '0;
      else if (read_en)
      begin
         case (paddr)
            AL_FRM_D_ADDR_L   : prdata <= d_addr_l;
            AL_FRM_D_ADDR_U   : prdata <= {16'd0, d_addr_u};
            AL_FRM_S_ADDR_L   : prdata <= s_addr_l;
            AL_FRM_S_ADDR_U   : prdata <= {16'd0, s_addr_u};
            AL_S_PORT         : prdata <= {30'd0, s_port};
            AL_D_PORT         : prdata <= {27'd0, d_port};
            AL_MAC_ADDR_L     : prdata <= mac_addr_l;
            AL_MAC_ADDR_U     : prdata <= {16'd0, mac_addr_u};
            AL_CUR_TIME       : prdata <= curr_time;
            AL_BB_AGE         : prdata <= bb_age;
            AL_DIV_CLK        : prdata <= {24'd0, div_clk};
            AL_STATUS         : prdata <= status;
            AL_LST_INV_ADDR_L : prdata <= lst_inv_addr_l;
            AL_LST_INV_ADDR_U : prdata <= {16'd0, lst_inv_addr_u};
            AL_LST_INV_PORT   : prdata <= {30'd0, lst_inv_port};
            default           : prdata <= '0;   // command and holes
         endcase
      end
      else
         prdata <= '0;   // only valid in the access phase
   end

   // ------------------------------------------------------------------
   // writable registers
   // ------------------------------------------------------------------
   always_ff @(posedge pclk3 or negedge n_p_reset3)
   begin
      if (!n_p_reset3)
      begin
         d_addr_l   <= '0;
         d_addr_u   <= '0;
         s_addr_l   <= '0;
         s_addr_u   <= '0;
         s_port     <= '0;
         mac_addr_l <= '0;
         mac_addr_u <= '0;
         bb_age     <= '1;     // nothing ages by default
         div_clk    <= '0;
      end
      else if (write_en)
      begin
         case (paddr)
            AL_FRM_D_ADDR_L : d_addr_l   <= pwdata;
            AL_FRM_D_ADDR_U : d_addr_u   <= pwdata[15:0];
            AL_FRM_S_ADDR_L : s_addr_l   <= pwdata;
            AL_FRM_S_ADDR_U : s_addr_u   <= pwdata[15:0];
            AL_S_PORT       : s_port     <= pwdata[1:0];
            AL_MAC_ADDR_L   : mac_addr_l <= pwdata;
            AL_MAC_ADDR_U   : mac_addr_u <= pwdata[15:0];
            AL_BB_AGE       : bb_age     <= pwdata;
            AL_DIV_CLK      : div_clk    <= pwdata[7:0];
            default         : ;
         endcase
      end
   end

   // command, cleared on the cycle after it is set
   always_ff @(posedge pclk3 or negedge n_p_reset3)
   begin
      if (!n_p_reset3)
         command <= CMD_NONE;
      else if (command != CMD_NONE)
         command <= CMD_NONE;
      else if (write_en && (paddr == AL_COMMAND) && !busy)
         command <= alut_cmd_t'(pwdata[1:0]);
   end

   // eviction wins over clear when both land together
   always_ff @(posedge pclk3 or negedge n_p_reset3)
   begin
      if (!n_p_reset3)
         reused <= 1'b0;
      else if (evt_nrm.strobe)
         reused <= 1'b1;
      else if (clear_reused)
         reused <= 1'b0;
   end

   // ------------------------------------------------------------------
   // last invalidated address and port
   // ------------------------------------------------------------------
   always_ff @(posedge pclk3 or negedge n_p_reset3)
   begin
      if (!n_p_reset3)
      begin
         lst_inv_addr_l <= '0;
         lst_inv_addr_u <= '0;
         lst_inv_port   <= '0;
      end
      else if (evt_nrm.strobe)          // eviction by the address checker
      begin
         lst_inv_addr_l <= evt_nrm.addr[31:0];
         lst_inv_addr_u <= evt_nrm.addr[47:32];
         lst_inv_port   <= evt_nrm.port;
      end
      else if (evt_age.strobe)          // aged out
      begin
         lst_inv_addr_l <= evt_age.addr[31:0];
         lst_inv_addr_u <= evt_age.addr[47:32];
         lst_inv_port   <= evt_age.port;
      end
   end

   // a transfer keeps its direction and address from setup into access
   a_no_rd_wr : assert property (@(posedge pclk3) disable iff (!n_p_reset3)
      (psel && penable) |-> ($stable(pwrite) && $stable(paddr)));

   // a valid command lasts one cycle and starts its checker
   a_cmd_pulse : assert property (@(posedge pclk3) disable iff (!n_p_reset3)
      ((command == CMD_CHECK) || (command == CMD_AGE)) |=>
      ((command == CMD_NONE) && busy));

   // the two checkers share one table port
   a_one_busy : assert property (@(posedge pclk3) disable iff (!n_p_reset3)
      !(add_check_active && age_check_active));

endmodule

// ==== src/alut_reg_pkg.sv ====
// register view of the ALUT, seen from the APB side
// byte offsets only, paddr[1:0] are expected to be 0
// command values above CMD_CHECK are accepted but start nothing

package alut_reg_pkg;

   typedef logic [6:0]  apb_addr_t;   // 7-bit byte address
   typedef logic [31:0] apb_data_t;

   // ------------------------------------------------------------------
   // register map
   // ------------------------------------------------------------------
   localparam apb_addr_t AL_FRM_D_ADDR_L   = 7'h00;
   localparam apb_addr_t AL_FRM_D_ADDR_U   = 7'h04;   // 16 bits used
   localparam apb_addr_t AL_FRM_S_ADDR_L   = 7'h08;
   localparam apb_addr_t AL_FRM_S_ADDR_U   = 7'h0C;   // 16 bits used
   localparam apb_addr_t AL_S_PORT         = 7'h10;
   localparam apb_addr_t AL_D_PORT         = 7'h14;   // read only
   localparam apb_addr_t AL_MAC_ADDR_L     = 7'h18;
   localparam apb_addr_t AL_MAC_ADDR_U     = 7'h1C;
   localparam apb_addr_t AL_CUR_TIME       = 7'h20;   // read only
   localparam apb_addr_t AL_BB_AGE         = 7'h24;
   localparam apb_addr_t AL_DIV_CLK        = 7'h28;
   localparam apb_addr_t AL_STATUS         = 7'h2C;   // read only
   localparam apb_addr_t AL_LST_INV_ADDR_L = 7'h30;
   localparam apb_addr_t AL_LST_INV_ADDR_U = 7'h34;
   localparam apb_addr_t AL_LST_INV_PORT   = 7'h38;
   localparam apb_addr_t AL_COMMAND        = 7'h3C;   // write only, reads 0

   // one-cycle command pulse to the checkers
   typedef enum logic [1:0] {
      CMD_NONE  = 2'd0,
      CMD_AGE   = 2'd1,    // invalidate aged entries
      CMD_CHECK = 2'd2     // look up d_addr, learn s_addr
   } alut_cmd_t;

   // configuration as the checkers see it
   typedef struct packed {
      logic [47:0] mac_addr;      // switch's own address
      logic [47:0] d_addr;        // frame destination
      logic [47:0] s_addr;        // frame source
      logic [1:0]  s_port;
      logic [31:0] best_bfr_age;
      logic [7:0]  div_clk;
   } alut_cfg_t;

   // AL_STATUS layout
   localparam int STATUS_BUSY_BIT   = 0;
   localparam int STATUS_AGING_BIT  = 1;
   localparam int STATUS_REUSED_BIT = 2;

endpackage

// ==== src/alut_table.sv ====
// eight entry table in flops, registered read, single write port
// the request of the busy checker is taken, age checker when sel_age
`timescale 1ns/1ns

module alut_table
   import alut_table_pkg::*;
(
   input  logic          pclk3,
   input  logic          n_p_reset3,
   input  logic          sel_age,
   input  alut_tbl_req_t req_nrm,
   input  alut_tbl_req_t req_age,
   output alut_entry_t   rd_entry
);

   alut_entry_t           mem [ALUT_DEPTH];
   logic [ALUT_DEPTH-1:0] vld;            // valid bits, cleared by reset
   alut_tbl_req_t         req;

   assign req = sel_age ? req_age : req_nrm;

   always_ff @(posedge pclk3 or negedge n_p_reset3)
   begin
      if (!n_p_reset3)
         vld <= '0;
      else if (req.wr_en)
         vld[req.wr_idx] <= req.wr_entry.valid;
   end

   // payload, valid taken from vld
   always_ff @(posedge pclk3)
   begin
      if (req.wr_en)
         mem[req.wr_idx] <= req.wr_entry;
      rd_entry       <= mem[req.rd_idx];
      rd_entry.valid <= vld[req.rd_idx];
   end

   a_one_writer : assert property (@(posedge pclk3) disable iff (!n_p_reset3)
      !(req_nrm.wr_en && req_age.wr_en));

endmodule

// ==== src/alut_table_pkg.sv ====
// table side types of the ALUT
// depth must stay a power of two, the round-robin pointer wraps freely

package alut_table_pkg;

   localparam int ALUT_DEPTH = 8;
   localparam int HOST_BIT   = 4;    // d_port bit for "to host"

   typedef logic [47:0] mac_addr_t;
   typedef logic [1:0]  alut_port_t;
   typedef logic [4:0]  alut_port_mask_t;   // [3:0] ports, [4] host
   typedef logic [31:0] alut_time_t;
   typedef logic [$clog2(ALUT_DEPTH)-1:0] alut_idx_t;

   typedef struct packed {
      logic       valid;
      mac_addr_t  mac;
      alut_port_t port;
      alut_time_t stamp;     // time of last learn
   } alut_entry_t;

   // eviction or aging, strobe is a single cycle
   typedef struct packed {
      logic       strobe;
      mac_addr_t  addr;
      alut_port_t port;
   } alut_inv_evt_t;

   // one read and one write request per cycle
   typedef struct packed {
      alut_idx_t   rd_idx;
      logic        wr_en;
      alut_idx_t   wr_idx;
      alut_entry_t wr_entry;
   } alut_tbl_req_t;

endpackage

// ==== src/alut_timebase.sv ====
// time base for the ALUT entry stamps
// curr_time advances once every div_clk+1 cycles of pclk3
// a new div_clk takes effect at the next reload
`timescale 1ns/1ns

module alut_timebase
   import alut_table_pkg::*;
(
   input  logic       pclk3,
   input  logic       n_p_reset3,
   input  logic [7:0] div_clk,
   output alut_time_t curr_time,
   output logic       tick
);

   logic [7:0] pre_cnt;   // prescaler, counts down

   assign tick = (pre_cnt == '0);

   always_ff @(posedge pclk3 or negedge n_p_reset3)
   begin
      if (!n_p_reset3)
      begin
         pre_cnt   <= '0;
         curr_time <= '0;
      end
      else if (tick)
      begin
         pre_cnt   <= div_clk;             // reload
         curr_time <= curr_time + 1'b1;    // wraps after 2^32
      end
      else
         pre_cnt <= pre_cnt - 1'b1;
   end

endmodule

// ==== src/alut_top.sv ====
// ALUT control slice, APB slave with no wait states
// d_port is valid once the busy bit in AL_STATUS clears
`timescale 1ns/1ns

module alut_top
   import alut_reg_pkg::*, alut_table_pkg::*;
(
   input  logic            pclk3,
   input  logic            n_p_reset3,
   input  logic            psel,
   input  logic            penable,
   input  logic            pwrite,
   input  apb_addr_t       paddr,
   input  apb_data_t       pwdata,
   output apb_data_t       prdata,
   output alut_port_mask_t d_port
);

   alut_cfg_t     cfg;
   alut_cmd_t     command;
   alut_time_t    curr_time;
   logic          add_check_active;
   logic          age_check_active;
   alut_inv_evt_t evt_nrm;
   alut_inv_evt_t evt_age;
   alut_tbl_req_t req_nrm;
   alut_tbl_req_t req_age;
   alut_entry_t   rd_entry;

   alut_reg_bank u_reg_bank (
      .pclk3            (pclk3),
      .n_p_reset3       (n_p_reset3),
      .psel             (psel),
      .penable          (penable),
      .pwrite           (pwrite),
      .paddr            (paddr),
      .pwdata           (pwdata),
      .curr_time        (curr_time),
      .add_check_active (add_check_active),
      .age_check_active (age_check_active),
      .d_port           (d_port),
      .evt_nrm          (evt_nrm),
      .evt_age          (evt_age),
      .cfg              (cfg),
      .command          (command),
      .prdata           (prdata)
   );

   // tick stays internal to the time base
   alut_timebase u_timebase (
      .pclk3      (pclk3),
      .n_p_reset3 (n_p_reset3),
      .div_clk    (cfg.div_clk),
      .curr_time  (curr_time),
      .tick       ()
   );

   alut_addr_check u_addr_check (
      .pclk3            (pclk3),
      .n_p_reset3       (n_p_reset3),
      .command          (command),
      .cfg              (cfg),
      .curr_time        (curr_time),
      .rd_entry         (rd_entry),
      .tbl_req          (req_nrm),
      .add_check_active (add_check_active),
      .d_port           (d_port),
      .evt_nrm          (evt_nrm)
   );

   alut_age_check u_age_check (
      .pclk3            (pclk3),
      .n_p_reset3       (n_p_reset3),
      .command          (command),
      .best_bfr_age     (cfg.best_bfr_age),
      .curr_time        (curr_time),
      .rd_entry         (rd_entry),
      .tbl_req          (req_age),
      .age_check_active (age_check_active),
      .evt_age          (evt_age)
   );

   alut_table u_table (
      .pclk3      (pclk3),
      .n_p_reset3 (n_p_reset3),
      .sel_age    (age_check_active),
      .req_nrm    (req_nrm),
      .req_age    (req_age),
      .rd_entry   (rd_entry)
   );

endmodule

// ==== tests/alut_tb.sv ====
// testbench for alut_top, driven by tests/alut_tests.txt
// run from the project root so the relative data file path resolves
// APB inputs change on the falling edge, outputs are sampled there too
// P polls AL_STATUS and compares the last (idle) status word
// that last idle status read also clears the sticky reused bit
`timescale 1ns/1ns

module alut_tb
   import alut_reg_pkg::*, alut_table_pkg::*;
();

   localparam int CLK_PERIOD = 20;
   localparam int MAX_POLLS  = 64;
   localparam     TEST_FILE  = "tests/alut_tests.txt";

   logic            pclk3;
   logic            n_p_reset3;
   logic            psel;
   logic            penable;
   logic            pwrite;
   apb_addr_t       paddr;
   apb_data_t       pwdata;
   apb_data_t       prdata;
   alut_port_mask_t d_port;

   int n_lines   = 0;    // sizes the watchdog
   int test_errs = 0;    // errors in the running test
   int err_total = 0;
   int pass_cnt  = 0;
   int fail_cnt  = 0;
   int fd;

   alut_top u_alut_top (
      .pclk3      (pclk3),
      .n_p_reset3 (n_p_reset3),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .d_port     (d_port)
   );

   initial
   begin
      pclk3 = 1'b0;
      forever
         #(CLK_PERIOD / 2) pclk3 = ~pclk3;
   end

   // ------------------------------------------------------------------
   // compare tasks
   // ------------------------------------------------------------------
   task automatic check_rdata(input apb_addr_t addr, input apb_data_t got,
                              input apb_data_t exp);
      if (got !== exp)
      begin
         $display("ERR %0t ns: read of 0x%02h gave %08h, expected %08h",
                  $time, addr, got, exp);
         test_errs++;
         err_total++;
      end
   endtask

   task automatic check_d_port(input alut_port_mask_t got, input alut_port_mask_t exp);
      if (got !== exp)
      begin
         $display("ERR %0t ns: d_port is %02h, expected %02h", $time, got, exp);
         test_errs++;
         err_total++;
      end
   endtask

   // ------------------------------------------------------------------
   // APB transfers, no wait states
   // ------------------------------------------------------------------
   task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
      @(negedge pclk3);
      psel    = 1'b1;       // setup
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge pclk3);
      penable = 1'b1;       // access, taken at next rising edge
      @(negedge pclk3);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
      @(negedge pclk3);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge pclk3);
      penable = 1'b1;
      data    = prdata;     // loaded at the setup edge
      @(negedge pclk3);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // poll until the busy bit drops, bounded
   task automatic wait_idle(input apb_data_t exp);
      apb_data_t st;
      int        polls;
      polls = 0;
      st    = 32'h1;        // pretend busy before the first read
      while (st[STATUS_BUSY_BIT] && (polls < MAX_POLLS))
      begin
         apb_read(AL_STATUS, st);
         polls++;
      end
      if (st[STATUS_BUSY_BIT])
      begin
         $display("status poll gave up after %0d reads at %0t ns, busy bit still set",
                  polls, $time);
         test_errs++;
         err_total++;
      end
      else
         check_rdata(AL_STATUS, st, exp);
   endtask

   task automatic count_lines(output int count);
      int             cfd;
      int             n;
      logic [8*128-1:0] line;
      count = 0;
      cfd   = $fopen(TEST_FILE, "r");
      if (cfd != 0)
      begin
         while (!$feof(cfd))
         begin
            n = $fgets(line, cfd);
            if (n != 0)
               count++;
         end
         $fclose(cfd);
      end
   endtask

   // ------------------------------------------------------------------
   // data file interpreter
   // ------------------------------------------------------------------
   task automatic run_tests(input int tfd);
      byte              op;
      int               got_op;
      int               n;
      apb_addr_t        addr;
      apb_data_t        data;
      apb_data_t        rdata;
      alut_port_mask_t  mask;
      logic [8*128-1:0] line;
      logic [8*32-1:0]  name;
      got_op = $fscanf(tfd, " %c", op);
      while (got_op == 1)
      begin
         case (op)
            "#" : n = $fgets(line, tfd);      // rest of a comment
            "W" :
            begin
               n = $fscanf(tfd, "%h %h", addr, data);
               apb_write(addr, data);
            end
            "R" :
            begin
               n = $fscanf(tfd, "%h %h", addr, data);
               apb_read(addr, rdata);
               check_rdata(addr, rdata, data);
            end
            "P" :
            begin
               n = $fscanf(tfd, "%h", data);   // expected idle status
               wait_idle(data);
            end
            "D" :
            begin
               n = $fscanf(tfd, "%h", mask);
               @(negedge pclk3);
               check_d_port(d_port, mask);
            end
            "T" :
            begin
               n = $fscanf(tfd, "%s", name);
               if (test_errs == 0)
               begin
                  $display("test %0s ok at %0t ns", name, $time);
                  pass_cnt++;
               end
               else
               begin
                  $display("test %0s failed with %0d errors", name, test_errs);
                  fail_cnt++;
               end
               test_errs = 0;
            end
            default :
            begin
               $display("unknown operation '%c' in the test file", op);
               err_total++;
            end
         endcase
         got_op = $fscanf(tfd, " %c", op);
      end
   endtask

   // ------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------
   initial
   begin
      n_p_reset3 = 1'b0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      count_lines(n_lines);
      repeat (2) @(posedge pclk3);     // reset for two cycles
      @(negedge pclk3);
      n_p_reset3 = 1'b1;
      fd = $fopen(TEST_FILE, "r");
      if (fd == 0)
      begin
         $display("could not open the test data file %0s", TEST_FILE);
         err_total++;
      end
      else
      begin
         run_tests(fd);
         $fclose(fd);
      end
      $display("tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_total);
      if ((err_total == 0) && (fail_cnt == 0) && (pass_cnt > 0))
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // watchdog, 64 cycles per data line
   initial
   begin
      wait (n_lines > 0);
      #(n_lines * 64 * CLK_PERIOD);
      $display("watchdog expired at %0t ns, the tests did not finish", $time);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// ==== tests/alut_tests.txt ====
# op and hex fields: W addr wdata, R addr expected, P expected idle status
# D expected d_port mask, T test name ends a test
R 00 00000000
R 04 00000000
R 10 00000000
R 14 00000000
R 24 ffffffff
R 28 00000000
R 2c 00000000
R 38 00000000
W 04 12345678
R 04 00005678
W 10 00000007
R 10 00000003
W 1c ffff1234
R 1c 00001234
W 24 0000beef
R 24 0000beef
W 24 ffffffff
W 28 00000003
R 28 00000003
W 28 00000000
R 40 00000000
R 7c 00000000
T reset_and_readback
# unknown destination floods all but port 1
W 08 00000001
W 0c 0000000a
W 10 00000001
W 00 00000099
W 04 0000000b
W 3c 00000002
R 3c 00000000
P 00000000
D 0d
R 14 0000000d
# destination is the source learned above
W 00 00000001
W 04 0000000a
W 08 00000002
W 10 00000002
W 3c 00000002
P 00000000
D 02
T command_and_learning
W 18 0000abcd
W 1c 0000ffff
W 00 0000abcd
W 04 0000ffff
W 3c 00000002
P 00000000
D 10
T host_address
# sources 3 to 8 fill entries 2 to 7
W 08 00000003
W 3c 00000002
P 00000000
W 08 00000004
W 3c 00000002
P 00000000
W 08 00000005
W 3c 00000002
P 00000000
W 08 00000006
W 3c 00000002
P 00000000
W 08 00000007
W 3c 00000002
P 00000000
W 08 00000008
W 3c 00000002
P 00000000
# ninth source evicts entry 0
W 08 00000009
W 3c 00000002
P 00000004
R 2c 00000000
R 30 00000001
R 34 0000000a
R 38 00000001
T eviction
W 3c 00000001
P 00000000
W 00 00000005
W 04 0000000a
W 3c 00000002
P 00000000
D 04
# zero age limit clears every entry
W 24 00000000
W 3c 00000001
P 00000000
R 30 00000008
R 34 0000000a
R 38 00000002
W 3c 00000002
P 00000000
D 0b
T aging
